// File: logic/avg_pkg.sv
package avg_pkg;

	// Width of one sample and of the reported average.
	localparam int SAMPLE_W = 8;

	// Samples past this count in one burst do not enter the sum.
	localparam int MAX_SAMPLES = 1000;

	// Wide enough to hold MAX_SAMPLES.
	localparam int CNT_W = 10;

	// Holds MAX_SAMPLES times the largest sample.
	localparam int SUM_W = 18;

	// Step counter of the divider, which counts up to SUM_W.
	localparam int STEP_W = $clog2(SUM_W + 1);

	typedef enum logic [1:0] {
		IDLE         = 2'd0,
		ACCUMULATING = 2'd1,
		DIVIDING     = 2'd2,
		AVG_OUT      = 2'd3
	} avg_state_t;

endpackage

// File: logic/div_if.sv
`timescale 1ns/100ps

// Link between the burst controller and the divider.
// Start is pulsed only while the divider is idle, and one done answers each start.
interface div_if;

	logic                       start;
	logic [avg_pkg::SUM_W-1:0]    dividend;
	logic [avg_pkg::CNT_W-1:0]    divisor;
	logic                       done;
	logic [avg_pkg::SAMPLE_W-1:0] quotient;

	modport ctrl (
		output start,
		output dividend,
		output divisor,
		input  done,
		input  quotient
	);

	modport div (
		input  start,
		input  dividend,
		input  divisor,
		output done,
		output quotient
	);

endinterface

// File: logic/avg_accum.sv
`timescale 1ns/100ps

module avg_accum (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic [avg_pkg::SAMPLE_W-1:0] data_in,
	input  logic                         dvalid,
	output logic [avg_pkg::SAMPLE_W-1:0] avg_out,
	output logic                         avg_valid,
	div_if.ctrl                          div
);

	import avg_pkg::*;

	avg_state_t state;
	avg_state_t next_state;

	logic             sample_take;
	logic             burst_first;
	logic             burst_end;
	logic             cnt_full;
	logic [CNT_W-1:0] sample_cnt;
	logic [SUM_W-1:0] sum;

	// A sample is taken in every state except while the divider runs.
	assign sample_take = dvalid && (state != DIVIDING);

	// The first sample of a burst restarts the sum and the count.
	assign burst_first = sample_take && (state != ACCUMULATING);

	// The first cycle without dvalid closes the burst.
	assign burst_end = (state == ACCUMULATING) && !dvalid;

	assign cnt_full = (sample_cnt == CNT_W'(MAX_SAMPLES));

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (dvalid) begin
					next_state = ACCUMULATING;
				end
			end
			ACCUMULATING: begin
				if (!dvalid) begin
					next_state = DIVIDING;
				end
			end
			DIVIDING: begin
				if (div.done) begin
					next_state = AVG_OUT;
				end
			end
			AVG_OUT: begin
				if (dvalid) begin
					next_state = ACCUMULATING;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// The count saturates at MAX_SAMPLES, so it also freezes the sum.
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sample_cnt <= '0;
		end else if (burst_first) begin
			sample_cnt <= CNT_W'(1);
		end else if (sample_take && !cnt_full) begin
			sample_cnt <= sample_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (burst_first) begin
			sum <= SUM_W'(data_in);
		end else if (sample_take && !cnt_full) begin
			sum <= sum + SUM_W'(data_in);
		end
	end

	// Start is high in the first DIVIDING cycle only.
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			div.start <= 1'b0;
		end else begin
			div.start <= burst_end;
		end
	end

	// The sum and count stay frozen for the whole division.
	assign div.dividend = sum;
	assign div.divisor  = sample_cnt;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			avg_out <= '0;
		end else if ((state == DIVIDING) && div.done) begin
			avg_out <= div.quotient;
		end
	end

	// Falls on the edge that takes the first sample of the next burst.
	assign avg_valid = (state == AVG_OUT);

endmodule

// File: logic/seq_divider.sv
`timescale 1ns/100ps

// Restoring divider with one quotient bit per cycle.
// The dividend shifts out at the top while quotient bits shift in at the bottom.
module seq_divider (
	input logic clk,
	input logic rstn,
	div_if.div  div
);

	import avg_pkg::*;

	logic              busy;
	logic              load;
	logic              last_step;
	logic [STEP_W-1:0] step;
	logic [SUM_W-1:0]  quo_sr;
	logic [CNT_W-1:0]  rem;
	logic [CNT_W:0]    rem_shift;
	logic [CNT_W:0]    rem_diff;
	logic              fits;
	logic [CNT_W-1:0]  rem_next;

	// A start that arrives while busy is not accepted.
	assign load = div.start && !busy;

	// The step that brings in the last dividend bit also raises done.
	assign last_step = (step == STEP_W'(SUM_W - 1));

	// Bring down the next dividend bit into the partial remainder.
	assign rem_shift = {rem, quo_sr[SUM_W-1]};
	assign rem_diff  = rem_shift - {1'b0, div.divisor};
	assign fits      = (rem_shift >= {1'b0, div.divisor});

	// The remainder is always below the divisor, so CNT_W bits hold it.
	always_comb begin
		if (fits) begin
			rem_next = rem_diff[CNT_W-1:0];
		end else begin
			rem_next = rem_shift[CNT_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			busy     <= 1'b0;
			step     <= '0;
			div.done <= 1'b0;
		end else begin
			div.done <= 1'b0;
			if (load) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				if (last_step) begin
					busy     <= 1'b0;
					div.done <= 1'b1;
				end else begin
					step <= step + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			quo_sr <= div.dividend;
			rem    <= '0;
		end else if (busy) begin
			quo_sr <= {quo_sr[SUM_W-2:0], fits};
			rem    <= rem_next;
		end
	end

	// The mean never exceeds the largest sample, so the low bits carry it all.
	// The register holds still in the done cycle.
	assign div.quotient = quo_sr[SAMPLE_W-1:0];

endmodule

// File: logic/sample_avg.sv
`timescale 1ns/100ps

module sample_avg (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic [avg_pkg::SAMPLE_W-1:0] data_in,
	input  logic                         dvalid,
	output logic [avg_pkg::SAMPLE_W-1:0] avg_out,
	output logic                         avg_valid
);

	// Carries the sum and the count to the divider and the quotient back.
	div_if div_bus ();

	avg_accum u_accum (
		.clk       (clk),
		.rstn      (rstn),
		.data_in   (data_in),
		.dvalid    (dvalid),
		.avg_out   (avg_out),
		.avg_valid (avg_valid),
		.div       (div_bus.ctrl)
	);

	seq_divider u_div (
		.clk  (clk),
		.rstn (rstn),
		.div  (div_bus.div)
	);

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/100ps

// Free-running clock and a reset that spans the first three cycles.
module tb_clkgen (
	output logic clk,
	output logic rstn
);

	initial begin
		clk = 1'b0;
		forever begin
			#50;
			clk = ~clk;
		end
	end

	// Reset is released on a falling edge, away from the sampling edge.
	initial begin
		rstn = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
	end

endmodule

// File: tb/sample_avg_chk.sv
`timescale 1ns/100ps

module sample_avg_chk (
	input logic                         clk,
	input logic                         rstn,
	input logic [avg_pkg::SAMPLE_W-1:0] avg_out,
	input logic                         avg_valid,
	input logic                         div_start,
	input logic                         div_done
);

	import avg_pkg::*;

	logic              div_pending;
	logic [STEP_W-1:0] div_age;

	// Counts the cycles since the divider was handed a start.
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			div_pending <= 1'b0;
			div_age     <= '0;
		end else if (div_start) begin
			div_pending <= 1'b1;
			div_age     <= '0;
		end else if (div_done) begin
			div_pending <= 1'b0;
		end else if (div_pending) begin
			div_age <= div_age + 1'b1;
		end
	end

	reset_quiet: assert property (@(posedge clk) !rstn |-> !avg_valid)
		else $error("avg_valid is high while reset is asserted");

	// In the cycle that is SUM_W+1 after start the age reads SUM_W.
	div_latency: assert property (@(posedge clk) disable iff (!rstn)
		div_pending |-> (div_age <= STEP_W'(SUM_W)))
		else $error("done did not follow start within SUM_W+1 cycles");

	done_after_start: assert property (@(posedge clk) disable iff (!rstn)
		div_done |-> div_pending)
		else $error("done pulsed with no division in progress");

	avg_held: assert property (@(posedge clk) disable iff (!rstn)
		(avg_valid && $past(avg_valid)) |-> $stable(avg_out))
		else $error("avg_out changed while avg_valid stayed high");

endmodule

// Watches the top level and the divider link inside it.
bind sample_avg sample_avg_chk u_chk (
	.clk       (clk),
	.rstn      (rstn),
	.avg_out   (avg_out),
	.avg_valid (avg_valid),
	.div_start (div_bus.start),
	.div_done  (div_bus.done)
);

// File: tb/tb_sample_avg.sv
`timescale 1ns/100ps

module tb_sample_avg;

	import avg_pkg::*;

	localparam int VALID_WAIT    = 100;
	localparam int ACK_WAIT      = 200;
	localparam int RESET_WAIT    = 10;
	localparam int RANDOM_BURSTS = 20;

	logic                clk;
	logic                rstn;
	logic [SAMPLE_W-1:0] data_in;
	logic                dvalid;
	logic [SAMPLE_W-1:0] avg_out;
	logic                avg_valid;

	integer              seed;
	logic [SAMPLE_W-1:0] burst_q[$];
	logic [SAMPLE_W-1:0] exp_avg;
	int                  req_cnt;
	int                  ack_cnt;
	int                  err_cnt;
	int                  err_at_start;
	int                  tests_run;
	int                  tests_failed;
	bit                  timed_out;
	string               test_name;

	tb_clkgen u_clkgen (
		.clk  (clk),
		.rstn (rstn)
	);

	sample_avg u_dut (
		.clk       (clk),
		.rstn      (rstn),
		.data_in   (data_in),
		.dvalid    (dvalid),
		.avg_out   (avg_out),
		.avg_valid (avg_valid)
	);

	// Truncated mean of the samples that fit in one burst.
	function automatic logic [SAMPLE_W-1:0] mean_of(input logic [SAMPLE_W-1:0] samples[$]);
		int n;
		int total;
		int i;
		n = samples.size();
		if (n > MAX_SAMPLES) begin
			n = MAX_SAMPLES;
		end
		total = 0;
		for (i = 0; i < n; i++) begin
			total += int'(samples[i]);
		end
		if (n == 0) begin
			return '0;
		end
		return SAMPLE_W'(total / n);
	endfunction

	task automatic open_test(input string name);
		test_name    = name;
		err_at_start = err_cnt;
	endtask

	task automatic report_test();
		tests_run++;
		if (err_cnt != err_at_start) begin
			tests_failed++;
			$display("%s: %0d errors", test_name, err_cnt - err_at_start);
		end else begin
			$display("%s: ok", test_name);
		end
	endtask

	// Feeds burst_q, then hands the expected mean to the compare process.
	task automatic send_burst(input bit expect_drop);
		int i;
		int waited;
		for (i = 0; i < burst_q.size(); i++) begin
			@(negedge clk);
			if (expect_drop && i == 1) begin
				assert (avg_valid == 1'b0) else begin
					$display("Fail at %0t: avg_valid expected 0, got %0b", $time, avg_valid);
					err_cnt++;
				end
			end
			data_in = burst_q[i];
			dvalid  = 1'b1;
		end
		@(negedge clk);
		dvalid  = 1'b0;
		data_in = '0;
		exp_avg = mean_of(burst_q);
		req_cnt++;
		waited = 0;
		while (ack_cnt != req_cnt && waited < ACK_WAIT) begin
			@(posedge clk);
			waited++;
		end
		if (ack_cnt != req_cnt) begin
			$display("Timeout: the result of the %s burst was never checked", test_name);
			timed_out = 1'b1;
			err_cnt++;
		end
	endtask

	// Checks each finished burst against the reference mean.
	initial begin : compare_results
		int waited;
		forever begin
			@(posedge clk);
			if (req_cnt != ack_cnt) begin
				waited = 0;
				@(negedge clk);
				while (!avg_valid && waited < VALID_WAIT) begin
					@(negedge clk);
					waited++;
				end
				if (!avg_valid) begin
					$display("Timeout: avg_valid never rose after the %s burst", test_name);
					timed_out = 1'b1;
					err_cnt++;
				end else begin
					assert (avg_out == exp_avg) else begin
						$display("Fail at %0t: avg_out expected %0d, got %0d",
							$time, exp_avg, avg_out);
						err_cnt++;
					end
				end
				ack_cnt = req_cnt;
			end
		end
	end

	initial begin : run_tests
		int b;
		int k;
		int len;
		int waited;
		integer rnd;
		seed         = 32'hc6c2b1ae;
		data_in      = '0;
		dvalid       = 1'b0;
		exp_avg      = '0;
		req_cnt      = 0;
		ack_cnt      = 0;
		err_cnt      = 0;
		err_at_start = 0;
		tests_run    = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		test_name    = "reset";

		waited = 0;
		while (!rstn && waited < RESET_WAIT) begin
			@(posedge clk);
			waited++;
		end
		if (!rstn) begin
			$display("Timeout: reset was never released");
			timed_out = 1'b1;
			err_cnt++;
		end

		if (!timed_out) begin
			open_test("reset");
			@(negedge clk);
			assert (avg_valid == 1'b0) else begin
				$display("Fail at %0t: avg_valid expected 0, got %0b", $time, avg_valid);
				err_cnt++;
			end
			assert (avg_out == '0) else begin
				$display("Fail at %0t: avg_out expected 0, got %0d", $time, avg_out);
				err_cnt++;
			end
			report_test();
		end

		if (!timed_out) begin
			open_test("single sample");
			burst_q = '{8'd173};
			send_burst(1'b0);
			report_test();
		end

		if (!timed_out) begin
			open_test("random bursts");
			// A mean of 1.5 must truncate to 1.
			burst_q = '{8'd1, 8'd2};
			send_burst(1'b0);
			for (b = 0; b < RANDOM_BURSTS && !timed_out; b++) begin
				burst_q.delete();
				rnd = $random(seed);
				len = 2 + ((rnd & 32'h7fffffff) % 39);
				for (k = 0; k < len; k++) begin
					rnd = $random(seed);
					burst_q.push_back(rnd[7:0]);
				end
				send_burst(1'b0);
			end
			report_test();
		end

		if (!timed_out) begin
			open_test("full scale");
			burst_q.delete();
			for (k = 0; k < MAX_SAMPLES; k++) begin
				burst_q.push_back(8'd255);
			end
			send_burst(1'b0);
			report_test();
		end

		if (!timed_out) begin
			open_test("overlong burst");
			burst_q.delete();
			for (k = 0; k < MAX_SAMPLES; k++) begin
				rnd = $random(seed);
				burst_q.push_back({1'b0, rnd[6:0]});
			end
			// These would raise the mean if they were counted.
			for (k = 0; k < 10; k++) begin
				burst_q.push_back(8'd255);
			end
			send_burst(1'b0);
			report_test();
		end

		if (!timed_out) begin
			open_test("restart");
			burst_q = '{8'd250, 8'd250, 8'd250};
			send_burst(1'b0);
			burst_q = '{8'd10, 8'd20, 8'd31};
			send_burst(1'b1);
			report_test();
		end

		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, err_cnt);
		if (err_cnt == 0 && !timed_out) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: build.f
logic/avg_pkg.sv
logic/div_if.sv
logic/avg_accum.sv
logic/seq_divider.sv
logic/sample_avg.sv
tb/tb_clkgen.sv
tb/sample_avg_chk.sv
tb/tb_sample_avg.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tb_sample_avg > build.log 2>&1 &&
./obj_dir/Vtb_sample_avg > sim.log 2>&1 ||
{ echo "Build or simulation aborted, see build.log and sim.log"; exit 1; }
grep -q "Test failed" sim.log &&
{ echo "Simulation reported a failure, see sim.log"; exit 1; }
echo "Simulation finished without failure"
exit 0
